// ==== fetch_realign.f ====
fetch_realign_pkg.sv
fetch_word_source.sv
realign_queue.sv
rvc_expander.sv
fetch_realign_top.sv
tb_clock_gen.sv
tb_stream_checker.sv
tb_fetch_realign.sv

// ==== fetch_realign_pkg.sv ====
`default_nettype none

package fetch_realign_pkg;

    // widths that carry a meaning in the fetch path.
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [15:0] half_t;
    typedef logic [4:0]  reg_idx_t;

    // a parcel whose two low bits are set starts a 32-bit instruction.
    localparam logic [1:0] FULL_LOW_BITS = 2'b11;

    // base isa major opcodes produced by the expander.
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef enum logic [1:0] {
        EMPTY,
        HALF_HELD,
        COMPRESSED_HELD,
        MISALIGNED
    } queue_state_t;

    // aligned memory word with its own address.
    typedef struct packed {
        word_t data;
        addr_t pc;
    } fetch_word_t;

    // one whole instruction; a compressed parcel sits in the low half.
    typedef struct packed {
        word_t instr;
        addr_t pc;
        logic  compressed;
    } instr_pkt_t;

    typedef struct packed {
        word_t instr;
        addr_t pc;
        logic  unsupported;
    } out_instr_t;

endpackage

`default_nettype wire

// ==== fetch_realign_testdata.txt ====
// header: test count; per test: word count, start pc, expected count, stall mode
// then one address/data pair per word, then one instr/pc/unsupported triple per line
7
// all 32-bit from address 0
4 0 4 0
0 00100093
4 00200113
8 00300193
c 00208233
00100093 0 0
00200113 4 0
00300193 8 0
00208233 c 0
// all compressed, two per word
4 40 8 0
40 04054415
44 65050001
48 8636058e
4c 963614fd
00500413 40 0
00140413 42 0
00000013 44 0
00001537 46 0
00359593 48 0
00d00633 4a 0
fff48493 4c 0
00d60633 4e 0
// mixed with straddling 32-bit instructions
5 80 7 0
80 00934415
84 04050010
88 123452b7
8c 82338636
90 00010020
00500413 80 0
00100093 82 0
00140413 86 0
123452b7 88 0
00d00633 8c 0
00208233 8e 0
00000013 92 0
// misaligned target, compressed
2 c2 2 0
c0 058e4398
c4 00200113
00359593 c2 0
00200113 c4 0
// misaligned target, 32-bit
3 e2 3 0
e0 00930001
e4 65050010
e8 00300193
00100093 e2 0
00001537 e6 0
00300193 e8 0
// unsupported compressed parcels
3 100 5 0
100 a0014398
104 00938082
108 44150010
00000000 100 1
00000000 102 1
00000000 104 1
00100093 106 0
00500413 10a 0
// mixed under random stall
6 140 9 1
140 00934415
144 04050010
148 963614fd
14c 82338636
150 058e0020
154 00200113
00500413 140 0
00100093 142 0
00140413 146 0
fff48493 148 0
00d60633 14a 0
00d00633 14c 0
00208233 14e 0
00359593 152 0
00200113 154 0

// ==== fetch_realign_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_realign_top #(
    parameter int IMEM_WORDS = 256
) (
    input  wire                                 clk_i,
    input  wire                                 rst_i,

    input  wire                                 imem_we_i,
    input  wire fetch_realign_pkg::addr_t       imem_addr_i,
    input  wire fetch_realign_pkg::word_t       imem_wdata_i,

    input  wire                                 redirect_i,
    input  wire fetch_realign_pkg::addr_t       redirect_pc_i,

    input  wire                                 stall_i,

    output logic                                out_valid_o,
    output fetch_realign_pkg::out_instr_t       out_o
);

    logic                           word_valid;
    fetch_realign_pkg::fetch_word_t word;
    logic                           word_take;
    logic                           pkt_valid;
    fetch_realign_pkg::instr_pkt_t  pkt;
    logic                           pkt_take;

    fetch_word_source #(
        .IMEM_WORDS (IMEM_WORDS)
    ) fetch_word_source_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .imem_we_i     (imem_we_i),
        .imem_addr_i   (imem_addr_i),
        .imem_wdata_i  (imem_wdata_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .word_take_i   (word_take),
        .word_valid_o  (word_valid),
        .word_o        (word)
    );

    realign_queue realign_queue_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .word_valid_i  (word_valid),
        .word_i        (word),
        .word_take_o   (word_take),
        .pkt_take_i    (pkt_take),
        .pkt_valid_o   (pkt_valid),
        .pkt_o         (pkt)
    );

    rvc_expander rvc_expander_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .stall_i     (stall_i),
        .pkt_valid_i (pkt_valid),
        .pkt_i       (pkt),
        .pkt_take_o  (pkt_take),
        .out_valid_o (out_valid_o),
        .out_o       (out_o)
    );

endmodule

`default_nettype wire

// ==== fetch_word_source.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_word_source #(
    parameter int IMEM_WORDS = 256
) (
    input  wire                                 clk_i,
    input  wire                                 rst_i,

    input  wire                                 imem_we_i,
    input  wire fetch_realign_pkg::addr_t       imem_addr_i,
    input  wire fetch_realign_pkg::word_t       imem_wdata_i,

    input  wire                                 redirect_i,
    input  wire fetch_realign_pkg::addr_t       redirect_pc_i,

    input  wire                                 word_take_i,
    output logic                                word_valid_o,
    output fetch_realign_pkg::fetch_word_t      word_o
);

    localparam int IDX_W = $clog2(IMEM_WORDS);

    fetch_realign_pkg::word_t       mem_q [IMEM_WORDS];
    fetch_realign_pkg::addr_t       fetch_addr_q;
    fetch_realign_pkg::fetch_word_t word_q;
    logic                           rd_req_q;
    logic                           word_valid_q;
    logic [IDX_W-1:0]               rd_idx;
    logic [IDX_W-1:0]               wr_idx;

    assign rd_idx = fetch_addr_q[IDX_W+1:2];
    assign wr_idx = imem_addr_i[IDX_W+1:2];

    // load port, word addressed.
    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            mem_q[wr_idx] <= imem_wdata_i;
        end
    end

    // fetch_addr_q always names the word being read or presented.
    // a take or redirect opens one bubble cycle while the read is issued.
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            fetch_addr_q <= '0;
            rd_req_q     <= 1'b1;
            word_valid_q <= 1'b0;
        end else if (redirect_i) begin
            fetch_addr_q <= {redirect_pc_i[31:2], 2'b00};
            rd_req_q     <= 1'b1;
            word_valid_q <= 1'b0;
        end else if (word_take_i && word_valid_q) begin
            fetch_addr_q <= fetch_addr_q + 32'd4;
            rd_req_q     <= 1'b1;
            word_valid_q <= 1'b0;
        end else if (rd_req_q) begin
            rd_req_q     <= 1'b0;
            word_valid_q <= 1'b1;
        end
    end

    // registered read, paired with its address.
    always_ff @(posedge clk_i) begin
        if (rd_req_q) begin
            word_q.data <= mem_q[rd_idx];
            word_q.pc   <= fetch_addr_q;
        end
    end

    assign word_valid_o = word_valid_q;
    assign word_o       = word_q;

endmodule

`default_nettype wire

// ==== realign_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module realign_queue (
    input  wire                                 clk_i,
    input  wire                                 rst_i,

    input  wire                                 redirect_i,
    input  wire fetch_realign_pkg::addr_t       redirect_pc_i,

    input  wire                                 word_valid_i,
    input  wire fetch_realign_pkg::fetch_word_t word_i,
    output logic                                word_take_o,

    input  wire                                 pkt_take_i,
    output logic                                pkt_valid_o,
    output fetch_realign_pkg::instr_pkt_t       pkt_o
);

    fetch_realign_pkg::queue_state_t state_q;
    fetch_realign_pkg::queue_state_t state_d;
    fetch_realign_pkg::queue_state_t hi_state;
    fetch_realign_pkg::half_t        held_q;
    fetch_realign_pkg::half_t        held_d;
    fetch_realign_pkg::addr_t        held_pc_q;
    fetch_realign_pkg::addr_t        held_pc_d;
    fetch_realign_pkg::half_t        word_lo;
    fetch_realign_pkg::half_t        word_hi;
    logic                            lo_full;
    logic                            hold_hi;

    assign word_lo = word_i.data[15:0];
    assign word_hi = word_i.data[31:16];
    assign lo_full = (word_lo[1:0] == fetch_realign_pkg::FULL_LOW_BITS);

    // where the queue goes once the high parcel is kept.
    assign hi_state = (word_hi[1:0] == fetch_realign_pkg::FULL_LOW_BITS) ?
                      fetch_realign_pkg::HALF_HELD : fetch_realign_pkg::COMPRESSED_HELD;

    always_comb begin
        state_d     = state_q;
        held_d      = held_q;
        held_pc_d   = held_pc_q;
        hold_hi     = 1'b0;
        pkt_valid_o = 1'b0;
        pkt_o       = '0;
        word_take_o = 1'b0;

        if (redirect_i) begin
            // old path is dropped, target alignment picks the start state.
            state_d = redirect_pc_i[1] ? fetch_realign_pkg::MISALIGNED : fetch_realign_pkg::EMPTY;
        end else begin
            case (state_q)
                fetch_realign_pkg::EMPTY: begin
                    if (word_valid_i) begin
                        pkt_valid_o = 1'b1;
                        pkt_o.pc    = word_i.pc;
                        if (lo_full) begin
                            pkt_o.instr = word_i.data;
                            word_take_o = pkt_take_i;
                        end else begin
                            pkt_o.instr      = {16'h0000, word_lo};
                            pkt_o.compressed = 1'b1;
                            hold_hi          = pkt_take_i;
                        end
                    end
                end
                fetch_realign_pkg::HALF_HELD: begin
                    if (word_valid_i) begin
                        pkt_valid_o = 1'b1;
                        pkt_o.instr = {word_lo, held_q};
                        pkt_o.pc    = held_pc_q;
                        hold_hi     = pkt_take_i;
                    end
                end
                fetch_realign_pkg::COMPRESSED_HELD: begin
                    // drains without touching the producer.
                    pkt_valid_o      = 1'b1;
                    pkt_o.instr      = {16'h0000, held_q};
                    pkt_o.pc         = held_pc_q;
                    pkt_o.compressed = 1'b1;
                    if (pkt_take_i) begin
                        state_d = fetch_realign_pkg::EMPTY;
                    end
                end
                fetch_realign_pkg::MISALIGNED: begin
                    if (word_valid_i) begin
                        if (hi_state == fetch_realign_pkg::HALF_HELD) begin
                            hold_hi = 1'b1;
                        end else begin
                            pkt_valid_o      = 1'b1;
                            pkt_o.instr      = {16'h0000, word_hi};
                            pkt_o.pc         = word_i.pc + 32'd2;
                            pkt_o.compressed = 1'b1;
                            word_take_o      = pkt_take_i;
                            if (pkt_take_i) begin
                                state_d = fetch_realign_pkg::EMPTY;
                            end
                        end
                    end
                end
                default: begin
                    state_d = fetch_realign_pkg::EMPTY;
                end
            endcase

            // the word is consumed and its high parcel kept.
            if (hold_hi) begin
                word_take_o = 1'b1;
                held_d      = word_hi;
                held_pc_d   = word_i.pc + 32'd2;
                state_d     = hi_state;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= fetch_realign_pkg::EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        held_q    <= held_d;
        held_pc_q <= held_pc_d;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch realign testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing \
    -f fetch_realign.f \
    --top-module tb_fetch_realign \
    -o sim_fetch_realign > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/sim_fetch_realign > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see $SIM_LOG"
    cat "$SIM_LOG"
    exit 1
fi

cat "$SIM_LOG"

if grep -q "^Testbench passed$" "$SIM_LOG"; then
    exit 0
fi

echo "pass message not found in $SIM_LOG"
exit 1

// ==== rvc_expander.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvc_expander (
    input  wire                                 clk_i,
    input  wire                                 rst_i,

    input  wire                                 stall_i,

    input  wire                                 pkt_valid_i,
    input  wire fetch_realign_pkg::instr_pkt_t  pkt_i,
    output logic                                pkt_take_o,

    output logic                                out_valid_o,
    output fetch_realign_pkg::out_instr_t       out_o
);

    fetch_realign_pkg::half_t      c;
    fetch_realign_pkg::reg_idx_t   rd;
    fetch_realign_pkg::reg_idx_t   rs2;
    logic [11:0]                   imm12;
    logic [19:0]                   imm20;
    fetch_realign_pkg::word_t      exp_instr;
    logic                          supported;
    fetch_realign_pkg::out_instr_t exp_d;

    assign c     = pkt_i.instr[15:0];
    assign rd    = c[11:7];
    assign rs2   = c[6:2];
    assign imm12 = {{6{c[12]}}, c[12], c[6:2]};
    assign imm20 = {{14{c[12]}}, c[12], c[6:2]};

    // only the register/immediate forms are expanded.
    always_comb begin
        exp_instr = '0;
        supported = 1'b0;
        case ({c[15:13], c[1:0]})
            5'b000_01: begin
                // c.addi, c.nop when rd is x0.
                exp_instr = {imm12, rd, 3'b000, rd, fetch_realign_pkg::OPC_OP_IMM};
                supported = 1'b1;
            end
            5'b010_01: begin
                exp_instr = {imm12, 5'd0, 3'b000, rd, fetch_realign_pkg::OPC_OP_IMM};
                supported = 1'b1;
            end
            5'b011_01: begin
                // rd of x2 is c.addi16sp.
                if (rd != 5'd2) begin
                    exp_instr = {imm20, rd, fetch_realign_pkg::OPC_LUI};
                    supported = 1'b1;
                end
            end
            5'b000_10: begin
                // shamt[5] is reserved on rv32.
                if (!c[12]) begin
                    exp_instr = {7'b0000000, rs2, rd, 3'b001, rd,
                                 fetch_realign_pkg::OPC_OP_IMM};
                    supported = 1'b1;
                end
            end
            5'b100_10: begin
                // rs2 of x0 is a jump or ebreak.
                if (rs2 != 5'd0) begin
                    if (c[12]) begin
                        exp_instr = {7'b0000000, rs2, rd, 3'b000, rd, fetch_realign_pkg::OPC_OP};
                    end else begin
                        exp_instr = {7'b0000000, rs2, 5'd0, 3'b000, rd, fetch_realign_pkg::OPC_OP};
                    end
                    supported = 1'b1;
                end
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // an unsupported parcel leaves exp_instr at zero.
    always_comb begin
        exp_d    = '0;
        exp_d.pc = pkt_i.pc;
        if (!pkt_i.compressed) begin
            exp_d.instr = pkt_i.instr;
        end else begin
            exp_d.instr       = exp_instr;
            exp_d.unsupported = !supported;
        end
    end

    assign pkt_take_o = pkt_valid_i && !stall_i;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            out_valid_o <= 1'b0;
        end else if (!stall_i) begin
            out_valid_o <= pkt_valid_i;
        end
    end

    // output register holds under stall.
    always_ff @(posedge clk_i) begin
        if (pkt_take_o) begin
            out_o <= exp_d;
        end
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    // 4 ns period.
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_fetch_realign.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_realign;

    localparam int IMEM_WORDS = 256;

    logic                          clk;
    logic                          rst;
    logic                          imem_we;
    fetch_realign_pkg::addr_t      imem_addr;
    fetch_realign_pkg::word_t      imem_wdata;
    logic                          redirect;
    fetch_realign_pkg::addr_t      redirect_pc;
    logic                          stall;
    logic                          out_valid;
    fetch_realign_pkg::out_instr_t out_instr;
    fetch_realign_pkg::out_instr_t cur_exp;

    logic        armed;
    logic [31:0] cur_test;
    logic [31:0] cur_base;
    logic [31:0] cur_n;
    logic [31:0] chk_count;
    logic        chk_done;
    logic [31:0] chk_errors;
    logic [31:0] chk_checked;

    logic [31:0] td [0:1023];
    logic [31:0] ld_addr [0:255];
    logic [31:0] ld_data [0:255];
    logic [31:0] exp_instr [0:255];
    logic [31:0] exp_pc [0:255];
    logic        exp_unsup [0:255];
    logic [31:0] t_word_base [0:15];
    logic [31:0] t_words [0:15];
    logic [31:0] t_start [0:15];
    logic [31:0] t_exp_base [0:15];
    logic [31:0] t_nexp [0:15];
    logic [31:0] t_stall [0:15];

    int          n_tests;
    int          total_exp;
    logic        parsed = 1'b0;
    logic [31:0] seed = 32'h1dd6_2f88;

    tb_clock_gen #(
        .RESET_CYCLES (10)
    ) tb_clock_gen_inst (
        .clk_o (clk),
        .rst_o (rst)
    );

    fetch_realign_top #(
        .IMEM_WORDS (IMEM_WORDS)
    ) fetch_realign_top_inst (
        .clk_i         (clk),
        .rst_i         (rst),
        .imem_we_i     (imem_we),
        .imem_addr_i   (imem_addr),
        .imem_wdata_i  (imem_wdata),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .stall_i       (stall),
        .out_valid_o   (out_valid),
        .out_o         (out_instr)
    );

    tb_stream_checker tb_stream_checker_inst (
        .clk_i       (clk),
        .armed_i     (armed),
        .stall_i     (stall),
        .out_valid_i (out_valid),
        .out_i       (out_instr),
        .exp_i       (cur_exp),
        .test_id_i   (cur_test),
        .n_exp_i     (cur_n),
        .count_o     (chk_count),
        .done_o      (chk_done),
        .errors_o    (chk_errors),
        .checked_o   (chk_checked)
    );

    always_comb begin
        cur_exp.instr       = exp_instr[cur_base + chk_count];
        cur_exp.pc          = exp_pc[cur_base + chk_count];
        cur_exp.unsupported = exp_unsup[cur_base + chk_count];
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic parse_testdata();
        int p;
        int nw;
        int ne;
        p         = 1;
        nw        = 0;
        ne        = 0;
        n_tests   = td[0];
        total_exp = 0;
        for (int t = 0; t < n_tests; t++) begin
            t_words[t]     = td[p];
            t_start[t]     = td[p + 1];
            t_nexp[t]      = td[p + 2];
            t_stall[t]     = td[p + 3];
            t_word_base[t] = nw;
            t_exp_base[t]  = ne;
            p = p + 4;
            for (int i = 0; i < int'(t_words[t]); i++) begin
                ld_addr[nw] = td[p];
                ld_data[nw] = td[p + 1];
                nw = nw + 1;
                p  = p + 2;
            end
            for (int i = 0; i < int'(t_nexp[t]); i++) begin
                exp_instr[ne] = td[p];
                exp_pc[ne]    = td[p + 1];
                exp_unsup[ne] = td[p + 2][0];
                ne = ne + 1;
                p  = p + 3;
            end
        end
        total_exp = ne;
    endtask

    task automatic run_test(input int t);
        for (int i = 0; i < int'(t_words[t]); i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= ld_addr[t_word_base[t] + i];
            imem_wdata <= ld_data[t_word_base[t] + i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        while (!rst) @(posedge clk);
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= t_start[t];
        cur_test    <= t + 1;
        cur_base    <= t_exp_base[t];
        cur_n       <= t_nexp[t];
        armed       <= 1'b1;
        @(posedge clk);
        redirect <= 1'b0;
        while (!chk_done) begin
            @(posedge clk);
            if (t_stall[t] != 0) begin
                seed = lcg_next(seed);
                stall <= seed[16];
            end else begin
                stall <= 1'b0;
            end
        end
        @(posedge clk);
        stall <= 1'b1;
        armed <= 1'b0;
    endtask

    initial begin
        imem_we     = 1'b0;
        imem_addr   = '0;
        imem_wdata  = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        stall       = 1'b1;
        armed       = 1'b0;
        cur_test    = '0;
        cur_base    = '0;
        cur_n       = '0;
        for (int i = 0; i < 1024; i++) begin
            td[i] = '0;
        end
        $readmemh("fetch_realign_testdata.txt", td);
        parse_testdata();
        parsed = 1'b1;
        if (n_tests == 0 || total_exp == 0) begin
            $display("no tests found in the data file");
        end
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        repeat (4) @(posedge clk);
        $display("summary: %0d tests, %0d of %0d instructions checked, %0d errors",
                 n_tests, chk_checked, total_exp, chk_errors);
        if (chk_errors == 0 && total_exp != 0 && chk_checked == total_exp) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // each instruction gets a generous budget of cycles.
    initial begin
        wait (parsed);
        repeat (total_exp * 40 + 100) @(posedge clk);
        $display("timeout: the expected instruction stream did not complete in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_stream_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_stream_checker (
    input  wire                                 clk_i,
    input  wire                                 armed_i,
    input  wire                                 stall_i,
    input  wire                                 out_valid_i,
    input  wire fetch_realign_pkg::out_instr_t  out_i,
    input  wire fetch_realign_pkg::out_instr_t  exp_i,
    input  wire [31:0]                          test_id_i,
    input  wire [31:0]                          n_exp_i,
    output logic [31:0]                         count_o,
    output logic                                done_o,
    output logic [31:0]                         errors_o,
    output logic [31:0]                         checked_o
);

    // stall seen at the edge that last loaded the output register.
    logic        stall_prev  = 1'b1;
    logic [31:0] count_q     = '0;
    logic        done_q      = 1'b0;
    logic [31:0] errors_q    = '0;
    logic [31:0] checked_q   = '0;
    logic [31:0] test_errs_q = '0;

    always @(posedge clk_i) begin
        logic [31:0] bad;
        bad = 0;
        stall_prev <= stall_i;
        if (!armed_i) begin
            count_q     <= '0;
            done_q      <= 1'b0;
            test_errs_q <= '0;
        end else if (!done_q && out_valid_i && !stall_prev) begin
            if (out_i.instr !== exp_i.instr) begin
                $display("ERROR %0t out_o.instr expected %h got %h",
                         $time, exp_i.instr, out_i.instr);
                bad = bad + 1;
            end
            if (out_i.pc !== exp_i.pc) begin
                $display("ERROR %0t out_o.pc expected %h got %h",
                         $time, exp_i.pc, out_i.pc);
                bad = bad + 1;
            end
            if (out_i.unsupported !== exp_i.unsupported) begin
                $display("ERROR %0t out_o.unsupported expected %b got %b",
                         $time, exp_i.unsupported, out_i.unsupported);
                bad = bad + 1;
            end
            count_q     <= count_q + 1;
            checked_q   <= checked_q + 1;
            errors_q    <= errors_q + bad;
            test_errs_q <= test_errs_q + bad;
            if (count_q + 1 == n_exp_i) begin
                done_q <= 1'b1;
                $display("test %0d done: %0d instructions, %0d mismatches",
                         test_id_i, n_exp_i, test_errs_q + bad);
            end
        end
    end

    assign count_o   = count_q;
    assign done_o    = done_q;
    assign errors_o  = errors_q;
    assign checked_o = checked_q;

endmodule

`default_nettype wire
